//--- logic/snd_mix_pkg.sv
package snd_mix_pkg;

    // Width of the mixed output
    localparam int MIX_W = 16;

    // Internal accumulator width, leaves headroom for the saturation check
    localparam int SUM_W = 24;

    // Volume setting from the DIP switches
    typedef enum logic [1:0] {
        VOL_LOW  = 2'd0,
        VOL_MID  = 2'd1,
        VOL_HIGH = 2'd2,
        VOL_MAX  = 2'd3
    } vol_step_e;

    // All gains are read as gain/16

    // PSG gain per volume step
    localparam logic [7:0] PSG_GAIN_LOW  = 8'h03;
    localparam logic [7:0] PSG_GAIN_MID  = 8'h06;
    localparam logic [7:0] PSG_GAIN_HIGH = 8'h08;
    localparam logic [7:0] PSG_GAIN_MAX  = 8'h0A;

    // FM is pulled down when PCM shares the output
    localparam logic [7:0] FM_GAIN_SOLO     = 8'h30;
    localparam logic [7:0] FM_GAIN_WITH_PCM = 8'h20;

    // PCM channel gain
    localparam logic [7:0] PCM_GAIN = 8'h0A;

endpackage

//--- logic/pcm_fetch_pkg.sv
package pcm_fetch_pkg;

    // Fetcher states
    // PTR_LO and PTR_HI read the two pointer bytes, PLAY streams data
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        PTR_LO = 2'd1,
        PTR_HI = 2'd2,
        PLAY   = 2'd3
    } pcm_state_e;

    // Start of the sample pointer table in ROM
    // Entry n sits at PTR_BASE + 2n, low byte first
    localparam logic [15:0] PTR_BASE = 16'h0090;

    // Mid-scale level of the unsigned PCM stream
    localparam logic [7:0] PCM_SILENCE = 8'h80;

endpackage

//--- logic/pcm_tick_gen.sv
module pcm_tick_gen #(
    parameter int TICK_DIV = 3
) (
    input  logic clk,
    input  logic comb_rstn,
    input  logic sample,
    output logic sample_edge,
    output logic pcm_tick
);

    logic                sample_l;
    logic                rise;
    logic [TICK_DIV-1:0] div_cnt;

    assign rise = sample & ~sample_l;

    // One-hot divider that advances on every strobe edge
    // The top bit being set marks the last edge of a group
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            sample_l    <= 1'b0;
            sample_edge <= 1'b0;
            pcm_tick    <= 1'b0;
            div_cnt     <= TICK_DIV'(1);
        end else begin
            sample_l    <= sample;
            sample_edge <= rise;
            pcm_tick    <= 1'b0;
            if (rise) begin
                div_cnt  <= (div_cnt << 1) | (div_cnt >> (TICK_DIV - 1));
                pcm_tick <= div_cnt[TICK_DIV-1];
            end
        end
    end

    // The divider always holds exactly one set bit
    a_div_onehot: assert property (
        @(posedge clk) disable iff (!comb_rstn)
        $onehot(div_cnt)
    );

endmodule

//--- logic/pcm_fetch.sv
module pcm_fetch (
    input  logic        clk,
    input  logic        comb_rstn,
    input  logic        pcm_tick,
    input  logic        cmd_trig,
    input  logic        pcm_ok,
    input  logic [5:0]  cmd_sel,
    input  logic [7:0]  pcm_data,
    output logic [15:0] pcm_addr,
    output logic [7:0]  pcm_level,
    output logic        pcm_busy,
    output logic        pcm_strobe
);
    import pcm_fetch_pkg::*;

    pcm_state_e state;
    logic [7:0] ptr_lsb;
    logic       trig_l;
    logic       trig_rise;
    logic       accept;
    logic       last_byte;

    // Command bit edge restarts playback
    assign trig_rise = cmd_trig & ~trig_l;

    // A ROM byte is only taken when the data is ready on a tick
    assign accept = pcm_tick & pcm_ok;

    // Zero byte or end of address space ends the sample
    assign last_byte = (pcm_data == 8'h00) || (&pcm_addr);

    assign pcm_busy = (state != IDLE);

    // Low half of the start pointer
    always_ff @(posedge clk) begin
        if (!trig_rise && accept && state == PTR_LO) begin
            ptr_lsb <= pcm_data;
        end
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            state      <= IDLE;
            pcm_addr   <= '0;
            pcm_level  <= PCM_SILENCE;
            pcm_strobe <= 1'b0;
            trig_l     <= 1'b0;
        end else begin
            trig_l     <= cmd_trig;
            pcm_strobe <= 1'b0;
            if (trig_rise) begin
                // Two bytes per table entry
                state    <= PTR_LO;
                pcm_addr <= PTR_BASE + {9'd0, cmd_sel, 1'b0};
            end else if (accept) begin
                case (state)
                    PTR_LO: begin
                        pcm_addr[0] <= 1'b1;
                        state       <= PTR_HI;
                    end
                    PTR_HI: begin
                        pcm_addr <= {pcm_data, ptr_lsb};
                        state    <= PLAY;
                    end
                    PLAY: begin
                        // The terminating zero is not played
                        if (last_byte) begin
                            pcm_level <= PCM_SILENCE;
                            state     <= IDLE;
                        end else begin
                            pcm_level <= pcm_data;
                        end
                        pcm_addr   <= pcm_addr + 16'd1;
                        pcm_strobe <= 1'b1;
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // Low pointer byte sits at the even address and the high byte at the odd one
    a_ptr_phase: assert property (
        @(posedge clk) disable iff (!comb_rstn)
        (state inside {PTR_LO, PTR_HI}) |-> (pcm_addr[0] == (state == PTR_HI))
    );

    // ROM back-pressure freezes the address unless a new command arrives
    a_addr_hold: assert property (
        @(posedge clk) disable iff (!comb_rstn)
        (!pcm_ok && !trig_rise) |=> $stable(pcm_addr)
    );

endmodule

//--- logic/pcm_dc_remove.sv
module pcm_dc_remove #(
    parameter int DC_SHIFT = 5
) (
    input  logic              clk,
    input  logic              comb_rstn,
    input  logic              pcm_strobe,
    input  logic [7:0]        pcm_level,
    output logic signed [7:0] pcm_ac
);

    localparam int AW = DC_SHIFT + 10;

    logic signed [7:0]    centered;
    logic signed [AW-1:0] avg_q;
    logic signed [AW-1:0] avg_int;
    logic signed [AW-1:0] avg_next;
    logic signed [9:0]    diff;
    logic signed [7:0]    diff_sat;

    // Flipping the MSB is the same as subtracting 128
    assign centered = {~pcm_level[7], pcm_level[6:0]};

    // avg_q holds the average scaled by 2^DC_SHIFT
    assign avg_int  = avg_q >>> DC_SHIFT;
    assign avg_next = avg_q + AW'(centered) - avg_int;

    assign diff = 10'(centered) - 10'(avg_int);

    always_comb begin
        if (diff > 10'sd127) begin
            diff_sat = 8'sh7F;
        end else if (diff < -10'sd128) begin
            diff_sat = 8'sh80;
        end else begin
            diff_sat = diff[7:0];
        end
    end

    // Average and output only step with a new PCM byte
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            avg_q  <= '0;
            pcm_ac <= '0;
        end else if (pcm_strobe) begin
            avg_q  <= avg_next;
            pcm_ac <= diff_sat;
        end
    end

endmodule

//--- logic/snd_mixer.sv
module snd_mixer (
    input  logic                              clk,
    input  logic                              comb_rstn,
    input  logic                              sample_edge,
    input  logic                              fm_en,
    input  logic                              psg_en,
    input  logic                              pcm_en,
    input  snd_mix_pkg::vol_step_e            fx_level,
    input  logic signed [15:0]                fm_snd,
    input  logic [9:0]                        psg_snd,
    input  logic signed [7:0]                 pcm_ac,
    output logic signed [snd_mix_pkg::MIX_W-1:0] snd,
    output logic                              peak
);
    import snd_mix_pkg::*;

    logic [7:0]              fm_gain;
    logic [7:0]              psg_gain;
    logic [7:0]              pcm_gain;
    logic signed [15:0]      psg_w;
    logic signed [15:0]      pcm_w;
    logic signed [SUM_W-1:0] sum;
    logic [SUM_W-MIX_W:0]    top_bits;
    logic                    ovf;

    // Channel times gain/16
    function automatic logic signed [SUM_W-1:0] scale(
        input logic signed [15:0] ch,
        input logic [7:0]         gain
    );
        logic signed [SUM_W-1:0] prod;
        prod = SUM_W'(ch) * SUM_W'(signed'({1'b0, gain}));
        return prod >>> 4;
    endfunction

    always_comb begin
        case (fx_level)
            VOL_LOW:  psg_gain = PSG_GAIN_LOW;
            VOL_MID:  psg_gain = PSG_GAIN_MID;
            VOL_HIGH: psg_gain = PSG_GAIN_HIGH;
            default:  psg_gain = PSG_GAIN_MAX;
        endcase
        if (!psg_en) begin
            psg_gain = '0;
        end
        // FM backs off while PCM is mixed in
        if (!fm_en) begin
            fm_gain = '0;
        end else if (pcm_en) begin
            fm_gain = FM_GAIN_WITH_PCM;
        end else begin
            fm_gain = FM_GAIN_SOLO;
        end
        pcm_gain = pcm_en ? PCM_GAIN : 8'h00;
    end

    // Bring PSG and PCM up to 16-bit scale
    assign psg_w = signed'({2'b00, psg_snd, 4'b0000});
    assign pcm_w = signed'({pcm_ac, 8'h00});

    assign sum = scale(fm_snd, fm_gain) + scale(psg_w, psg_gain) + scale(pcm_w, pcm_gain);

    // Fits in MIX_W bits when all bits above the sign agree with it
    assign top_bits = sum[SUM_W-1:MIX_W-1];
    assign ovf      = (top_bits != '0) && (top_bits != '1);

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            snd  <= '0;
            peak <= 1'b0;
        end else if (sample_edge) begin
            peak <= ovf;
            if (!ovf) begin
                snd <= sum[MIX_W-1:0];
            end else if (sum[SUM_W-1]) begin
                snd <= {1'b1, {(MIX_W-1){1'b0}}};
            end else begin
                snd <= {1'b0, {(MIX_W-1){1'b1}}};
            end
        end
    end

endmodule

//--- logic/pcm_sound_top.sv
module pcm_sound_top #(
    parameter int TICK_DIV = 3,
    parameter int DC_SHIFT = 5
) (
    input  logic                                 clk,
    input  logic                                 comb_rstn,
    input  logic                                 sample,
    input  logic                                 cmd_trig,
    input  logic [5:0]                           cmd_sel,
    input  logic [7:0]                           pcm_data,
    input  logic                                 pcm_ok,
    input  logic signed [15:0]                   fm_snd,
    input  logic [9:0]                           psg_snd,
    input  snd_mix_pkg::vol_step_e               fx_level,
    input  logic                                 fm_en,
    input  logic                                 psg_en,
    input  logic                                 pcm_en,
    output logic [15:0]                          pcm_addr,
    output logic                                 pcm_busy,
    output logic signed [snd_mix_pkg::MIX_W-1:0] snd,
    output logic                                 peak
);

    logic              sample_edge;
    logic              pcm_tick;
    logic              pcm_strobe;
    logic [7:0]        pcm_level;
    logic signed [7:0] pcm_ac;

    pcm_tick_gen #(.TICK_DIV(TICK_DIV)) u_tick (
        .clk         ( clk         ),
        .comb_rstn   ( comb_rstn   ),
        .sample      ( sample      ),
        .sample_edge ( sample_edge ),
        .pcm_tick    ( pcm_tick    )
    );

    pcm_fetch u_fetch (
        .clk         ( clk         ),
        .comb_rstn   ( comb_rstn   ),
        .pcm_tick    ( pcm_tick    ),
        .cmd_trig    ( cmd_trig    ),
        .pcm_ok      ( pcm_ok      ),
        .cmd_sel     ( cmd_sel     ),
        .pcm_data    ( pcm_data    ),
        .pcm_addr    ( pcm_addr    ),
        .pcm_level   ( pcm_level   ),
        .pcm_busy    ( pcm_busy    ),
        .pcm_strobe  ( pcm_strobe  )
    );

    pcm_dc_remove #(.DC_SHIFT(DC_SHIFT)) u_dcrm (
        .clk         ( clk         ),
        .comb_rstn   ( comb_rstn   ),
        .pcm_strobe  ( pcm_strobe  ),
        .pcm_level   ( pcm_level   ),
        .pcm_ac      ( pcm_ac      )
    );

    snd_mixer u_mixer (
        .clk         ( clk         ),
        .comb_rstn   ( comb_rstn   ),
        .sample_edge ( sample_edge ),
        .fm_en       ( fm_en       ),
        .psg_en      ( psg_en      ),
        .pcm_en      ( pcm_en      ),
        .fx_level    ( fx_level    ),
        .fm_snd      ( fm_snd      ),
        .psg_snd     ( psg_snd     ),
        .pcm_ac      ( pcm_ac      ),
        .snd         ( snd         ),
        .peak        ( peak        )
    );

endmodule

//--- dv/pcm_sound_tb.sv
module pcm_sound_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import snd_mix_pkg::*;

    localparam int          TICK_DIV      = 3;
    localparam int          STROBE_PERIOD = 4;
    localparam int          RESET_CYCLES  = 8;
    localparam int          BYTE_TIMEOUT  = 2000;
    localparam int          EDGE_TIMEOUT  = 4 * STROBE_PERIOD;
    localparam int          KW_W          = 64;
    localparam logic [15:0] TABLE_BASE    = 16'h0090;

    logic clk;
    logic comb_rstn;
    logic sample;
    logic cmd_trig;
    logic [5:0] cmd_sel;
    logic [7:0] pcm_data;
    logic pcm_ok;
    logic signed [15:0] fm_snd;
    logic [9:0] psg_snd;
    vol_step_e fx_level;
    logic fm_en;
    logic psg_en;
    logic pcm_en;
    logic [15:0] pcm_addr;
    logic pcm_busy;
    logic signed [15:0] snd;
    logic peak;

    logic [7:0] rom [65536];
    logic [31:0] lfsr;
    int strobe_cnt;
    int rise_cnt;
    logic tick_pend;
    logic tick_now;
    logic acc_now;

    // Values read from the stimulus file
    int fd;
    int n;
    int cut;
    logic [KW_W-1:0] kw;
    logic [8*16-1:0] case_name;
    logic [8*128-1:0] line;
    logic [15:0] rom_a;
    logic [7:0] rom_d;
    logic [5:0] sel_a;
    logic [5:0] sel_b;
    logic [15:0] first_a;
    logic [15:0] first_b;
    logic [15:0] last_a;
    logic [15:0] m_fm;
    logic [15:0] m_psg;
    logic [15:0] m_vol;
    logic [15:0] m_fe;
    logic [15:0] m_pe;
    logic [15:0] m_snd;
    logic [15:0] m_peak;

    pcm_sound_top #(.TICK_DIV(TICK_DIV), .DC_SHIFT(5)) pcm_sound_top_i (
        .clk(clk), .comb_rstn(comb_rstn), .sample(sample), .cmd_trig(cmd_trig),
        .cmd_sel(cmd_sel), .pcm_data(pcm_data), .pcm_ok(pcm_ok), .fm_snd(fm_snd),
        .psg_snd(psg_snd), .fx_level(fx_level), .fm_en(fm_en), .psg_en(psg_en),
        .pcm_en(pcm_en), .pcm_addr(pcm_addr), .pcm_busy(pcm_busy), .snd(snd), .peak(peak)
    );

    always #50 clk = ~clk;

    // ROM answers combinationally
    assign pcm_data = rom[pcm_addr];

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic abort_run(input string why);
        $display("%0s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("mismatch %0s %0s expected %0h actual %0h",
                                case_name, what, expected, actual));
        end
    endtask

    // One clock step on the falling edge with strobe, ROM ready and tick model
    task automatic cycle();
        @(negedge clk);
        tick_now  = tick_pend;
        tick_pend = 1'b0;
        sample    = (strobe_cnt == 0);
        if (sample) begin
            rise_cnt  = rise_cnt + 1;
            // Tick shows up the cycle after every TICK_DIV-th rise
            tick_pend = (rise_cnt % TICK_DIV == 0);
        end
        strobe_cnt = (strobe_cnt + 1) % STROBE_PERIOD;
        lfsr       = lfsr_step(lfsr);
        pcm_ok     = lfsr[0];
        acc_now    = tick_now & pcm_ok;
    endtask

    task automatic trigger(input logic [5:0] sel);
        cycle();
        cmd_sel  = sel;
        cmd_trig = 1'b1;
        cycle();
        cmd_trig = 1'b0;
        check_value("table_addr", 32'(TABLE_BASE + 16'(sel) * 16'd2), 32'(pcm_addr));
        check_value("busy_start", 32'd1, 32'(pcm_busy));
    endtask

    // Table low, table high, then first up to last; stops early after cut reads
    task automatic follow(input logic [5:0] sel, input logic [15:0] first,
                          input logic [15:0] last, input int max_reads);
        int total;
        int reads;
        int idle;
        logic [15:0] tbl;
        logic [15:0] want;
        logic [15:0] prev;
        logic prev_acc;
        tbl      = TABLE_BASE + 16'(sel) * 16'd2;
        total    = 3 + int'(last - first);
        reads    = 0;
        idle     = 0;
        prev     = pcm_addr;
        prev_acc = 1'b0;
        if (max_reads < total) begin
            total = max_reads;
        end
        while (reads < total) begin
            if (!prev_acc) begin
                check_value("addr_hold", 32'(prev), 32'(pcm_addr));
            end
            check_value("busy_play", 32'd1, 32'(pcm_busy));
            if (acc_now) begin
                want = (reads < 2) ? tbl + 16'(reads) : first + 16'(reads - 2);
                check_value("fetch_addr", 32'(want), 32'(pcm_addr));
                reads = reads + 1;
                idle  = 0;
            end else begin
                idle = idle + 1;
                if (idle > BYTE_TIMEOUT) begin
                    abort_run("timeout: no accepted ROM read while a sample was playing");
                end
            end
            prev     = pcm_addr;
            prev_acc = acc_now;
            if (reads < total) begin
                cycle();
            end
        end
        if (total < max_reads) begin
            cycle();
            check_value("busy_end", 32'd0, 32'(pcm_busy));
        end
    endtask

    task automatic mix_case();
        int r0;
        int waited;
        cycle();
        pcm_en   = 1'b0;
        fm_snd   = m_fm;
        psg_snd  = m_psg[9:0];
        fx_level = vol_step_e'(m_vol[1:0]);
        fm_en    = m_fe[0];
        psg_en   = m_pe[0];
        r0       = rise_cnt;
        waited   = 0;
        while (rise_cnt == r0) begin
            cycle();
            waited = waited + 1;
            if (waited > EDGE_TIMEOUT) begin
                abort_run("timeout: the sample strobe never rose");
            end
        end
        // Edge pulse and then the mixer register
        cycle();
        cycle();
        check_value("snd", 32'(m_snd), 32'($unsigned(snd)));
        check_value("peak", 32'(m_peak), 32'(peak));
    endtask

    initial begin
        clk        = 1'b0;
        comb_rstn  = 1'b0;
        sample     = 1'b0;
        cmd_trig   = 1'b0;
        cmd_sel    = '0;
        pcm_ok     = 1'b0;
        fm_snd     = '0;
        psg_snd    = '0;
        fx_level   = VOL_LOW;
        fm_en      = 1'b0;
        psg_en     = 1'b0;
        pcm_en     = 1'b0;
        lfsr       = 32'ha918_5e05;
        strobe_cnt = 1;
        rise_cnt   = 0;
        tick_pend  = 1'b0;
        tick_now   = 1'b0;
        acc_now    = 1'b0;
        // Never zero so only the file places sample terminators
        for (int a = 0; a < 65536; a++) begin
            rom[16'(a)] = (a[15:8] ^ a[7:0]) | 8'h01;
        end
        fd = $fopen("dv/pcm_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/pcm_stimulus.txt");
        end
        repeat (RESET_CYCLES) @(negedge clk);
        case_name = "reset";
        check_value("busy", 32'd0, 32'(pcm_busy));
        check_value("peak", 32'd0, 32'(peak));
        check_value("snd", 32'd0, 32'($unsigned(snd)));
        check_value("addr", 32'd0, 32'(pcm_addr));
        comb_rstn = 1'b1;
        while ($fscanf(fd, "%s", kw) == 1) begin
            if (kw == KW_W'("#")) begin
                n = $fgets(line, fd);
            end else if (kw == KW_W'("rom")) begin
                n = $fscanf(fd, "%h %h", rom_a, rom_d);
                if (n != 2) begin
                    abort_run("malformed rom line in the stimulus file");
                end
                rom[rom_a] = rom_d;
            end else if (kw == KW_W'("play")) begin
                n = $fscanf(fd, "%s %h %h %h", case_name, sel_a, first_a, last_a);
                trigger(sel_a);
                follow(sel_a, first_a, last_a, 1 << 17);
            end else if (kw == KW_W'("restart")) begin
                n = $fscanf(fd, "%s %h %h %h %h %h %h", case_name, sel_a, first_a, cut,
                            sel_b, first_b, last_a);
                trigger(sel_a);
                follow(sel_a, first_a, 16'hffff, cut);
                trigger(sel_b);
                follow(sel_b, first_b, last_a, 1 << 17);
            end else if (kw == KW_W'("mix")) begin
                n = $fscanf(fd, "%s %h %h %h %h %h %h %h", case_name, m_fm, m_psg, m_vol,
                            m_fe, m_pe, m_snd, m_peak);
                mix_case();
            end else begin
                abort_run("unknown line type in the stimulus file");
            end
        end
        $fclose(fd);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- pcm_sound_top.f
logic/snd_mix_pkg.sv
logic/pcm_fetch_pkg.sv
logic/pcm_tick_gen.sv
logic/pcm_fetch.sv
logic/pcm_dc_remove.sv
logic/snd_mixer.sv
logic/pcm_sound_top.sv
dv/pcm_sound_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := pcm_sound_tb
FILELIST := pcm_sound_top.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The testbench ends every failing run with $fatal, so the exit status is the result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/pcm_stimulus.txt
# rom <addr> <byte> | play <name> <sel> <first> <last> | restart <name> <sel> <first> <cut>
# <sel2> <first2> <last2> | mix <name> <fm> <psg> <vol> <fm_en> <psg_en> <snd> <peak>, all hex
rom 0090 00
rom 0091 02
rom 0094 00
rom 0095 03
rom 009a 34
rom 009b 12
rom 010e fc
rom 010f ff
rom 0203 00
rom 1236 00
rom 0308 00
play short_zero 00 0200 0203
play addr_wrap 3f fffc ffff
restart retrigger 02 0300 4 05 1234 1236
mix all_on 0400 100 1 1 1 1200 0
mix neg_sum fc00 3ff 0 1 1 fffd 0
mix fm_off 1000 080 3 0 1 0500 0
mix psg_off 1000 3ff 2 1 0 3000 0
mix sat_pos 3000 3ff 3 1 1 7fff 1
mix sat_neg 8000 000 0 1 0 8000 1
mix peak_clear 0010 000 0 1 1 0030 0
